//--- Makefile
VERILATOR ?= verilator
TOP       ?= move_gen_tb
FLIST     ?= flist.f
BUILD_DIR ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --binary --timing -Wno-fatal -j 0

FAIL_MSG := Simulation failed
PASS_MSG := Simulation completed successfully

.PHONY: help build test clean

help:
	@echo "targets:"
	@echo "  test   build with Verilator, run, and check $(LOG)"
	@echo "  clean  remove $(BUILD_DIR) and $(LOG)"
	@echo "  help   show this list"

build:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FLIST) --Mdir $(BUILD_DIR)

test: build
	./$(BUILD_DIR)/V$(TOP) > $(LOG) 2>&1; cat $(LOG)
	@if grep -q "$(FAIL_MSG)" $(LOG); then \
		echo "test FAILED, see $(LOG)"; exit 1; \
	fi
	@if ! grep -q "$(PASS_MSG)" $(LOG); then \
		echo "test did not finish, see $(LOG)"; exit 1; \
	fi

clean:
	rm -rf $(BUILD_DIR) $(LOG)

//--- flist.f
logic/chess_board_pkg.sv
logic/move_gen_pkg.sv
logic/move_apply.sv
logic/move_sequencer.sv
logic/position_store.sv
logic/move_gen_top.sv
verif/move_gen_tb.sv

//--- logic/chess_board_pkg.sv
`default_nettype none

package chess_board_pkg;

   // bit 3 is colour, bits 2..0 are the kind
   typedef logic [3:0] piece_t;
   typedef logic [2:0] kind_t;

   localparam piece_t PIECE_EMPTY = 4'd0;
   localparam piece_t PIECE_PAWN  = 4'd1;
   localparam piece_t PIECE_KNIT  = 4'd2;
   localparam piece_t PIECE_BISH  = 4'd3;
   localparam piece_t PIECE_ROOK  = 4'd4;
   localparam piece_t PIECE_QUEN  = 4'd5;
   localparam piece_t PIECE_KING  = 4'd6;

   localparam int BLACK_BIT = 3;

   typedef piece_t [63:0] board_t;    // square = row * 8 + col, row 0 is white home

   // signed so that steps off the edge show up as out of range
   typedef logic signed [4:0] coord_t;

   function automatic kind_t piece_kind(input piece_t p);
      return p[BLACK_BIT-1:0];
   endfunction

   function automatic logic is_black(input piece_t p);
      return p[BLACK_BIT];
   endfunction

   function automatic logic [5:0] square_index(input coord_t row, input coord_t col);
      return {row[2:0], col[2:0]};
   endfunction

   function automatic logic on_board(input coord_t row, input coord_t col);
      return row[4:3] == 2'b00 && col[4:3] == 2'b00;    // 0..7 on both axes
   endfunction

endpackage

`default_nettype wire

//--- logic/move_apply.sv
`timescale 1ns/1ps
`default_nettype none

module move_apply
   import chess_board_pkg::*, move_gen_pkg::*;
(
   input  board_t     board,
   input  coord_t     origin_row,
   input  coord_t     origin_col,
   input  coord_t     target_row,
   input  coord_t     target_col,
   input  piece_t     piece,
   input  logic       white_to_move,
   output logic [1:0] target_class,
   output position_t  position
);

   logic [5:0] origin_sq;
   logic [5:0] target_sq;
   piece_t     target_piece;

   assign origin_sq    = square_index(origin_row, origin_col);
   assign target_sq    = square_index(target_row, target_col);
   assign target_piece = board[target_sq];    // wraps when off board, class masks it

   always_comb
   begin
      if (!on_board(target_row, target_col))
         target_class = TGT_OFF;
      else if (piece_kind(target_piece) == PIECE_EMPTY[2:0])
         target_class = TGT_EMPTY;
      else if (is_black(target_piece) == !white_to_move)
         target_class = TGT_OWN;
      else
         target_class = TGT_ENEMY;
   end

   always_comb
   begin
      position.board            = board;
      position.board[origin_sq] = PIECE_EMPTY;
      position.board[target_sq] = piece;
      position.capture          = target_class == TGT_ENEMY;
      position.white_to_move    = !white_to_move;
   end

endmodule

`default_nettype wire

//--- logic/move_gen_pkg.sv
`default_nettype none

package move_gen_pkg;
   import chess_board_pkg::*;

   typedef struct packed {
      board_t board;
      logic   capture;
      logic   white_to_move;
   } position_t;

   // classes of the target square
   localparam logic [1:0] TGT_OFF   = 2'd0;
   localparam logic [1:0] TGT_EMPTY = 2'd1;
   localparam logic [1:0] TGT_OWN   = 2'd2;
   localparam logic [1:0] TGT_ENEMY = 2'd3;

   // rows of the direction tables
   localparam logic [1:0] CLASS_QUEEN_KING = 2'd0;
   localparam logic [1:0] CLASS_ROOK       = 2'd1;
   localparam logic [1:0] CLASS_BISHOP     = 2'd2;
   localparam logic [1:0] CLASS_KNIGHT     = 2'd3;

   typedef logic signed [2:0] offset_t;

   localparam offset_t DIR_ROW [4][8] = '{
      '{-3'sd1, -3'sd1, -3'sd1,  3'sd0,  3'sd0,  3'sd1,  3'sd1,  3'sd1},  // queen, king
      '{ 3'sd0,  3'sd0,  3'sd1, -3'sd1,  3'sd0,  3'sd0,  3'sd0,  3'sd0},  // rook
      '{ 3'sd1,  3'sd1, -3'sd1, -3'sd1,  3'sd0,  3'sd0,  3'sd0,  3'sd0},  // bishop
      '{-3'sd2, -3'sd1,  3'sd1,  3'sd2,  3'sd2,  3'sd1, -3'sd1, -3'sd2}   // knight
   };

   localparam offset_t DIR_COL [4][8] = '{
      '{-3'sd1,  3'sd0,  3'sd1, -3'sd1,  3'sd1, -3'sd1,  3'sd0,  3'sd1},
      '{ 3'sd1, -3'sd1,  3'sd0,  3'sd0,  3'sd0,  3'sd0,  3'sd0,  3'sd0},
      '{ 3'sd1, -3'sd1,  3'sd1, -3'sd1,  3'sd0,  3'sd0,  3'sd0,  3'sd0},
      '{-3'sd1, -3'sd2, -3'sd2, -3'sd1,  3'sd1,  3'sd2,  3'sd2,  3'sd1}
   };

   localparam logic [3:0] DIR_COUNT [4] = '{4'd8, 4'd4, 4'd4, 4'd8};

   function automatic logic [1:0] piece_class(input kind_t kind);
      if (kind == PIECE_KNIT[2:0])
         return CLASS_KNIGHT;
      else if (kind == PIECE_ROOK[2:0])
         return CLASS_ROOK;
      else if (kind == PIECE_BISH[2:0])
         return CLASS_BISHOP;
      else
         return CLASS_QUEEN_KING;    // queen and king share offsets
   endfunction

   function automatic logic is_slider(input kind_t kind);
      return kind == PIECE_QUEN[2:0] || kind == PIECE_ROOK[2:0] || kind == PIECE_BISH[2:0];
   endfunction

endpackage

`default_nettype wire

//--- logic/move_gen_top.sv
`timescale 1ns/1ps
`default_nettype none

module move_gen_top
   import chess_board_pkg::*, move_gen_pkg::*;
#(
   parameter int MAX_MOVES = 256,
   localparam int COUNT_W = $clog2(MAX_MOVES + 1)
)
(
   input  logic               clk,
   input  logic               reset,
   input  logic               board_valid,
   input  logic               white_to_move_in,
   input  logic               clear_moves,
   input  board_t             board_in,
   input  logic [COUNT_W-1:0] move_index,
   output logic               moves_ready,
   output logic               move_ready,
   output logic               capture_out,
   output logic               white_to_move_out,
   output logic [COUNT_W-1:0] move_count,
   output board_t             board_out
);

   board_t     board;
   coord_t     origin_row;
   coord_t     origin_col;
   coord_t     target_row;
   coord_t     target_col;
   piece_t     piece;
   logic       white_to_move;
   logic [1:0] target_class;
   position_t  new_position;
   position_t  rd_position;
   logic       wr;
   logic       wr_clear;

   move_sequencer #(
      .MAX_MOVES (MAX_MOVES)
   ) move_sequencer_i (
      .clk              (clk),
      .reset            (reset),
      .board_valid      (board_valid),
      .white_to_move_in (white_to_move_in),
      .clear_moves      (clear_moves),
      .board_in         (board_in),
      .target_class     (target_class),
      .write_count      (move_count),
      .board            (board),
      .origin_row       (origin_row),
      .origin_col       (origin_col),
      .target_row       (target_row),
      .target_col       (target_col),
      .piece            (piece),
      .white_to_move    (white_to_move),
      .wr               (wr),
      .wr_clear         (wr_clear),
      .moves_ready      (moves_ready)
   );

   move_apply move_apply_i (
      .board         (board),
      .origin_row    (origin_row),
      .origin_col    (origin_col),
      .target_row    (target_row),
      .target_col    (target_col),
      .piece         (piece),
      .white_to_move (white_to_move),
      .target_class  (target_class),
      .position      (new_position)
   );

   position_store #(
      .MAX_MOVES (MAX_MOVES)
   ) position_store_i (
      .clk         (clk),
      .wr          (wr),
      .wr_clear    (wr_clear),
      .wr_data     (new_position),
      .rd_index    (move_index),
      .rd_data     (rd_position),
      .write_count (move_count),
      .rd_stable   (move_ready)
   );

   assign board_out         = rd_position.board;
   assign capture_out       = rd_position.capture;
   assign white_to_move_out = rd_position.white_to_move;

endmodule

`default_nettype wire

//--- logic/move_sequencer.sv
`timescale 1ns/1ps
`default_nettype none

module move_sequencer
   import chess_board_pkg::*, move_gen_pkg::*;
#(
   parameter int MAX_MOVES = 256,
   localparam int COUNT_W = $clog2(MAX_MOVES + 1)
)
(
   input  logic               clk,
   input  logic               reset,
   input  logic               board_valid,
   input  logic               white_to_move_in,
   input  logic               clear_moves,
   input  board_t             board_in,
   input  logic [1:0]         target_class,
   input  logic [COUNT_W-1:0] write_count,
   output board_t             board,
   output coord_t             origin_row,
   output coord_t             origin_col,
   output coord_t             target_row,
   output coord_t             target_col,
   output piece_t             piece,
   output logic               white_to_move,
   output logic               wr,
   output logic               wr_clear,
   output logic               moves_ready
);

   typedef enum logic [1:0] {S_IDLE, S_SQUARE, S_MOVE, S_DONE} state_t;

   state_t     state;
   logic [2:0] dir_index;
   logic [2:0] next_dir;
   piece_t     square;
   kind_t      square_kind;
   logic [1:0] square_class;
   logic [1:0] move_class;
   logic       movable;
   logic       last_square;
   logic       last_dir;
   logic       continue_ray;
   logic       store_full;
   coord_t     next_row;
   coord_t     next_col;

   assign square       = board[square_index(origin_row, origin_col)];
   assign square_kind  = piece_kind(square);
   assign square_class = piece_class(square_kind);
   assign move_class   = piece_class(piece_kind(piece));

   // own knight, king or slider; pawns only block
   assign movable = square_kind != PIECE_EMPTY[2:0] &&
                    is_black(square) == !white_to_move &&
                    (is_slider(square_kind) ||
                     square_kind == PIECE_KNIT[2:0] ||
                     square_kind == PIECE_KING[2:0]);

   assign last_square  = origin_row == 5'sd7 && origin_col == 5'sd7;
   assign last_dir     = {1'b0, dir_index} == DIR_COUNT[move_class] - 4'd1;
   assign continue_ray = is_slider(piece_kind(piece)) && target_class == TGT_EMPTY;
   assign store_full   = write_count == COUNT_W'(MAX_MOVES);
   assign next_dir     = dir_index + 3'd1;

   // column runs fastest
   assign next_col = (origin_col == 5'sd7) ? 5'sd0 : origin_col + 5'sd1;
   assign next_row = (origin_col == 5'sd7) ? origin_row + 5'sd1 : origin_row;

   assign wr          = state == S_MOVE &&
                        (target_class == TGT_EMPTY || target_class == TGT_ENEMY);
   assign wr_clear    = state == S_IDLE;
   assign moves_ready = state == S_DONE;

   always_ff @(posedge clk)
   begin
      if (reset)
         state <= S_IDLE;
      else
      begin
         case (state)
            S_IDLE:
               if (board_valid)
                  state <= S_SQUARE;
            S_SQUARE:
               if (store_full)
                  state <= S_DONE;    // nothing more fits
               else if (movable)
                  state <= S_MOVE;
               else if (last_square)
                  state <= S_DONE;
            S_MOVE:
               if (!continue_ray && last_dir)
                  state <= last_square ? S_DONE : S_SQUARE;
            S_DONE:
               if (clear_moves)
                  state <= S_IDLE;
            default:
               state <= S_IDLE;
         endcase
      end
   end

   always_ff @(posedge clk)
   begin
      case (state)
         S_IDLE:
         begin
            if (board_valid)
            begin
               board         <= board_in;
               white_to_move <= white_to_move_in;
            end
            origin_row <= '0;
            origin_col <= '0;
         end
         S_SQUARE:
         begin
            piece      <= square;
            dir_index  <= '0;
            target_row <= origin_row + DIR_ROW[square_class][0];
            target_col <= origin_col + DIR_COL[square_class][0];
            if (!movable)
            begin
               origin_row <= next_row;
               origin_col <= next_col;
            end
         end
         S_MOVE:
         begin
            if (continue_ray)
            begin
               // one more step along the same ray
               target_row <= target_row + DIR_ROW[move_class][dir_index];
               target_col <= target_col + DIR_COL[move_class][dir_index];
            end
            else if (!last_dir)
            begin
               dir_index  <= next_dir;
               target_row <= origin_row + DIR_ROW[move_class][next_dir];
               target_col <= origin_col + DIR_COL[move_class][next_dir];
            end
            else
            begin
               origin_row <= next_row;
               origin_col <= next_col;
            end
         end
         default:
         begin
         end
      endcase
   end

endmodule

`default_nettype wire

//--- logic/position_store.sv
`timescale 1ns/1ps
`default_nettype none

module position_store
   import move_gen_pkg::*;
#(
   parameter int MAX_MOVES = 256,
   localparam int COUNT_W = $clog2(MAX_MOVES + 1)
)
(
   input  logic               clk,
   input  logic               wr,
   input  logic               wr_clear,
   input  position_t          wr_data,
   input  logic [COUNT_W-1:0] rd_index,
   output position_t          rd_data,
   output logic [COUNT_W-1:0] write_count,
   output logic               rd_stable
);

   localparam int ADDR_W = $clog2(MAX_MOVES);

   position_t          mem [MAX_MOVES];
   logic [COUNT_W-1:0] rd_index_q;
   logic               full;
   logic               accept;

   assign full   = write_count == COUNT_W'(MAX_MOVES);
   assign accept = wr && !full;    // extra writes dropped

   always_ff @(posedge clk)
   begin
      if (wr_clear)
         write_count <= '0;
      else if (accept)
         write_count <= write_count + 1'b1;
   end

   always_ff @(posedge clk)
   begin
      if (accept)
         mem[write_count[ADDR_W-1:0]] <= wr_data;
   end

   always_ff @(posedge clk)
   begin
      if (rd_index < COUNT_W'(MAX_MOVES))
         rd_data <= mem[rd_index[ADDR_W-1:0]];
      else
         rd_data <= '0;    // past the end reads as zero
      rd_index_q <= rd_index;
      rd_stable  <= rd_index == rd_index_q;    // same index on two edges
   end

endmodule

`default_nettype wire

//--- verif/move_gen_tb.sv
`timescale 1ns/1ps
`default_nettype none

module move_gen_tb
   import chess_board_pkg::*;
();

   localparam int     MAX_MOVES    = 256;
   localparam int     COUNT_W      = $clog2(MAX_MOVES + 1);
   localparam int     SCAN_TIMEOUT = 4000;
   localparam int     READ_TIMEOUT = 20;
   localparam piece_t BLK          = 4'b1000;

   // offsets in generator output order
   localparam int KQ_DR [8] = '{-1, -1, -1, 0, 0, 1, 1, 1};
   localparam int KQ_DC [8] = '{-1, 0, 1, -1, 1, -1, 0, 1};
   localparam int RK_DR [4] = '{0, 0, 1, -1};
   localparam int RK_DC [4] = '{1, -1, 0, 0};
   localparam int BS_DR [4] = '{1, 1, -1, -1};
   localparam int BS_DC [4] = '{1, -1, 1, -1};
   localparam int KN_DR [8] = '{-2, -1, 1, 2, 2, 1, -1, -2};
   localparam int KN_DC [8] = '{-1, -2, -2, -1, 1, 2, 2, 1};

   logic               clk = 1'b0;
   logic               reset;
   logic               board_valid;
   logic               white_to_move_in;
   logic               clear_moves;
   board_t             board_in;
   logic [COUNT_W-1:0] move_index;
   logic               moves_ready;
   logic               move_ready;
   logic               capture_out;
   logic               white_to_move_out;
   logic [COUNT_W-1:0] move_count;
   board_t             board_out;

   board_t exp_board [$];
   logic   exp_cap [$];
   int     errors       = 0;
   int     tests_run    = 0;
   int     tests_failed = 0;

   always #5 clk = ~clk;

   move_gen_top #(
      .MAX_MOVES (MAX_MOVES)
   ) move_gen_top_i (
      .clk               (clk),
      .reset             (reset),
      .board_valid       (board_valid),
      .white_to_move_in  (white_to_move_in),
      .clear_moves       (clear_moves),
      .board_in          (board_in),
      .move_index        (move_index),
      .moves_ready       (moves_ready),
      .move_ready        (move_ready),
      .capture_out       (capture_out),
      .white_to_move_out (white_to_move_out),
      .move_count        (move_count),
      .board_out         (board_out)
   );

   // walk one direction from (row, col), pushing every reachable position
   task automatic add_ray(input board_t b, input int row, input int col,
                          input int dr, input int dc, input bit slide);
      int     tr;
      int     tc;
      bit     stop;
      piece_t mover;
      piece_t target;
      board_t nb;
      mover = b[row * 8 + col];
      tr    = row + dr;
      tc    = col + dc;
      stop  = 1'b0;
      while (!stop && tr >= 0 && tr < 8 && tc >= 0 && tc < 8)
      begin
         target = b[tr * 8 + tc];
         if (target[2:0] != 3'd0 && target[3] == mover[3])
            stop = 1'b1;    // own piece blocks
         else
         begin
            nb                = b;
            nb[row * 8 + col] = PIECE_EMPTY;
            nb[tr * 8 + tc]   = mover;
            exp_board.push_back(nb);
            exp_cap.push_back(target[2:0] != 3'd0);
            stop = target[2:0] != 3'd0 || !slide;
            tr   = tr + dr;
            tc   = tc + dc;
         end
      end
   endtask

   task automatic build_expected(input board_t b, input bit wtm);
      piece_t p;
      int     sq;
      int     k;
      exp_board.delete();
      exp_cap.delete();
      for (sq = 0; sq < 64; sq++)
      begin
         p = b[sq];
         if (p[2:0] != 3'd0 && p[3] == !wtm)
         begin
            case (p & 4'b0111)
               PIECE_KNIT:
                  for (k = 0; k < 8; k++)
                     add_ray(b, sq / 8, sq % 8, KN_DR[k], KN_DC[k], 1'b0);
               PIECE_BISH:
                  for (k = 0; k < 4; k++)
                     add_ray(b, sq / 8, sq % 8, BS_DR[k], BS_DC[k], 1'b1);
               PIECE_ROOK:
                  for (k = 0; k < 4; k++)
                     add_ray(b, sq / 8, sq % 8, RK_DR[k], RK_DC[k], 1'b1);
               PIECE_QUEN:
                  for (k = 0; k < 8; k++)
                     add_ray(b, sq / 8, sq % 8, KQ_DR[k], KQ_DC[k], 1'b1);
               PIECE_KING:
                  for (k = 0; k < 8; k++)
                     add_ray(b, sq / 8, sq % 8, KQ_DR[k], KQ_DC[k], 1'b0);
               default:
               begin
               end
            endcase
         end
      end
   endtask

   task automatic wait_moves_ready(input string name, input logic level, output bit ok);
      int cycles;
      cycles = 0;
      while (moves_ready !== level && cycles < SCAN_TIMEOUT)
      begin
         @(negedge clk);
         cycles++;
      end
      ok = moves_ready === level;
      if (!ok)
      begin
         $display("Timeout in %s: moves_ready never went to %0d", name, level);
         errors++;
      end
   endtask

   task automatic wait_move_ready(input string name, output bit ok);
      int cycles;
      cycles = 0;
      while (move_ready !== 1'b1 && cycles < READ_TIMEOUT)
      begin
         @(negedge clk);
         cycles++;
      end
      ok = move_ready === 1'b1;
      if (!ok)
      begin
         $display("Timeout in %s: move_ready stayed low at index %0d", name, move_index);
         errors++;
      end
   endtask

   task automatic check_record(input string name, input int idx, input bit wtm);
      if (board_out !== exp_board[idx])
      begin
         $display("Mismatch %s board at %0d: expected %h actual %h",
                  name, idx, exp_board[idx], board_out);
         errors++;
      end
      if (capture_out !== exp_cap[idx])
      begin
         $display("Mismatch %s capture at %0d: expected %0d actual %0d",
                  name, idx, exp_cap[idx], capture_out);
         errors++;
      end
      if (white_to_move_out !== !wtm)
      begin
         $display("Mismatch %s white_to_move at %0d: expected %0d actual %0d",
                  name, idx, !wtm, white_to_move_out);
         errors++;
      end
   endtask

   // load a board, read every record back, then clear
   task automatic run_board(input string name, input board_t b, input bit wtm,
                            input int exp_n);
      int                 n;
      int                 idx;
      bit                 ok;
      bit                 rd_ok;
      logic [COUNT_W-1:0] prev_index;
      build_expected(b, wtm);
      n = exp_board.size();
      @(negedge clk);
      board_in         = b;
      white_to_move_in = wtm;
      board_valid      = 1'b1;
      @(negedge clk);
      board_valid = 1'b0;
      wait_moves_ready(name, 1'b1, ok);
      if (ok)
      begin
         if (move_count !== COUNT_W'(n))
         begin
            $display("Mismatch %s count: expected %0d actual %0d", name, n, move_count);
            errors++;
         end
         if (move_count !== COUNT_W'(exp_n))
         begin
            $display("Mismatch %s count: expected %0d actual %0d", name, exp_n, move_count);
            errors++;
         end
         for (idx = 0; idx < n; idx++)
         begin
            prev_index = move_index;
            move_index = COUNT_W'(idx);
            @(negedge clk);
            // a new index has been seen on one edge only
            if (move_index != prev_index && move_ready !== 1'b0)
            begin
               $display("Mismatch %s move_ready at %0d: expected 0 actual %0d",
                        name, idx, move_ready);
               errors++;
            end
            wait_move_ready(name, rd_ok);
            if (rd_ok)
               check_record(name, idx, wtm);
         end
      end
      @(negedge clk);
      clear_moves = 1'b1;
      wait_moves_ready(name, 1'b0, ok);
      clear_moves = 1'b0;
   endtask

   task automatic finish_test(input string name, input int start_errors);
      tests_run++;
      if (errors == start_errors)
         $display("test %s passed", name);
      else
      begin
         tests_failed++;
         $display("test %s failed with %0d errors", name, errors - start_errors);
      end
   endtask

   task automatic test_reset_state();
      int start;
      int cyc;
      start = errors;
      for (cyc = 0; cyc < 8; cyc++)
      begin
         @(negedge clk);
         if (moves_ready !== 1'b0)
         begin
            $display("Mismatch reset_state moves_ready: expected 0 actual %0d", moves_ready);
            errors++;
         end
      end
      if (move_count !== '0)
      begin
         $display("Mismatch reset_state count: expected 0 actual %0d", move_count);
         errors++;
      end
      finish_test("reset_state", start);
   endtask

   task automatic test_lone_knight();
      board_t b;
      int     start;
      start = errors;
      b     = '0;
      b[0]  = PIECE_KNIT;    // a1
      run_board("lone_knight", b, 1'b1, 2);
      finish_test("lone_knight", start);
   endtask

   task automatic test_blocked_rook();
      board_t b;
      int     start;
      start = errors;
      b     = '0;
      b[0]  = PIECE_ROOK;
      b[16] = PIECE_PAWN;           // a3, own blocker
      b[3]  = BLK | PIECE_KNIT;     // d1, captured
      run_board("blocked_rook", b, 1'b1, 4);
      finish_test("blocked_rook", start);
   endtask

   task automatic test_central_queen();
      board_t b;
      int     start;
      start = errors;
      b     = '0;
      b[27] = PIECE_QUEN;    // d4
      run_board("central_queen", b, 1'b1, 27);
      finish_test("central_queen", start);
   endtask

   task automatic test_black_to_move();
      board_t b;
      int     start;
      start = errors;
      b     = '0;
      b[4]  = PIECE_KING;
      b[7]  = PIECE_ROOK;
      b[12] = PIECE_PAWN;
      b[45] = PIECE_KNIT;
      b[34] = BLK | PIECE_BISH;
      b[51] = BLK | PIECE_PAWN;
      b[53] = BLK | PIECE_PAWN;
      b[59] = BLK | PIECE_QUEN;
      b[60] = BLK | PIECE_KING;
      b[62] = BLK | PIECE_KNIT;
      // bishop 11, queen 8, king 2, knight 3
      run_board("black_to_move", b, 1'b0, 24);
      finish_test("black_to_move", start);
   endtask

   task automatic test_empty_side_repeat();
      board_t b;
      int     start;
      int     sq;
      start = errors;
      b     = '0;
      for (sq = 8; sq < 16; sq++)
         b[sq] = PIECE_PAWN;    // pawns generate nothing
      run_board("empty_side", b, 1'b1, 0);
      b     = '0;
      b[63] = PIECE_KING;
      b[54] = BLK | PIECE_ROOK;
      run_board("repeat_board", b, 1'b1, 3);
      finish_test("empty_side_repeat", start);
   endtask

   initial
   begin
      reset            = 1'b1;
      board_valid      = 1'b0;
      white_to_move_in = 1'b1;
      clear_moves      = 1'b0;
      board_in         = '0;
      move_index       = '0;
      repeat (2) @(negedge clk);
      reset = 1'b0;
      test_reset_state();
      test_lone_knight();
      test_blocked_rook();
      test_central_queen();
      test_black_to_move();
      test_empty_side_repeat();
      $display("tests run %0d, failed %0d, errors %0d", tests_run, tests_failed, errors);
      if (errors == 0)
         $display("Simulation completed successfully");
      else
         $display("Simulation failed");
      $finish;
   end

endmodule

`default_nettype wire
